// ==== run.sh ====
#!/bin/sh
# builds the loader testbench with Verilator and runs it
# exits non-zero when the build, the run or the testbench fails

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f src.f --top-module tb_cart_loader -o tb_cart_loader
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_cart_loader > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" "$log"; then
	exit 1
fi
exit 0

// ==== src.f ====
+incdir+test
src/loader_pkg.sv
src/loader_if.sv
src/beat_capture.sv
src/word_assembler.sv
src/write_router.sv
src/cart_loader_top.sv
test/tb_cart_loader.sv

// ==== src/beat_capture.sv ====
// first loader stage, registers the host download port
// decodes the download kind and forwards boot-ROM and cartridge halves
// also owns the cart-loaded flag and the ROM copy start for the main console

`timescale 1ns/1ps

module beat_capture import loader_pkg::*; (
	input  logic       clk_1x,
	input  logic       arst_n,
	input  logic       ioctl_download,
	input  dl_index_t  ioctl_index,
	input  byte_addr_t ioctl_addr,
	input  half_t      ioctl_dout,
	input  logic       ioctl_wr,
	beat_if.src        beat,
	output logic       romcopy_start,
	output byte_addr_t romcopy_size,
	output logic       cart_loaded
);

	// ========================================================================
	// input registers
	// ========================================================================

	logic       dl_q;
	logic       dl_d;
	logic       wr_q;
	dl_index_t  idx_q;
	byte_addr_t addr_q;
	half_t      dout_q;
	dl_kind_t   kind;
	logic       fwd_kind;
	logic       n64_fall;

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			dl_q <= 1'b0;
			dl_d <= 1'b0;
			wr_q <= 1'b0;
		end else begin
			dl_q <= ioctl_download;
			dl_d <= dl_q;
			wr_q <= ioctl_wr;
		end
	end

	always_ff @(posedge clk_1x) begin
		idx_q  <= ioctl_index;
		addr_q <= ioctl_addr;
		dout_q <= ioctl_dout;
	end

	// classify from the registered level, unknown codes give none
	always_comb begin
		kind = DL_NONE;
		if (dl_q) begin
			case (idx_q[IDX_CODE_W-1:0])
				IDX_PIF: kind = DL_PIF;
				IDX_N64: kind = DL_N64;
				IDX_GB:  kind = DL_GB;
				default: kind = DL_NONE;
			endcase
		end
	end

	// only boot ROM and cartridge data go down the pipe
	assign fwd_kind = (kind == DL_PIF) || (kind == DL_GB);

	// main-console download just ended
	assign n64_fall = dl_d && !dl_q && (idx_q[IDX_CODE_W-1:0] == IDX_N64);

	// ========================================================================
	// beat output and main-console status
	// ========================================================================

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			beat.wr       <= 1'b0;
			romcopy_start <= 1'b0;
			cart_loaded   <= 1'b0;
		end else begin
			beat.wr       <= wr_q && fwd_kind;
			romcopy_start <= n64_fall;
			// sticky until reset
			if (kind == DL_N64) begin
				cart_loaded <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_1x) begin
		beat.kind <= kind;
		beat.addr <= addr_q;
		beat.data <= dout_q;
		beat.bank <= idx_q[IDX_BANK_BIT];
		// final byte count at the fall
		if (n64_fall) begin
			romcopy_size <= addr_q;
		end
	end

	// copy start only for a main-console ROM that was loaded
	a_copy_after_load: assert property (
		@(posedge clk_1x) disable iff (!arst_n) romcopy_start |-> cart_loaded
	) else $error("romcopy_start without a loaded main-console ROM");

endmodule

// ==== src/cart_loader_top.sv ====
// top level of the cartridge and boot-ROM loader
// host download port in, boot-ROM write port and RAM write channel out
// pipeline of beat capture, word assembly and write routing

`timescale 1ns/1ps

module cart_loader_top import loader_pkg::*; (
	input  logic       clk_1x,
	input  logic       arst_n,
	// host download port
	input  logic       ioctl_download,
	input  dl_index_t  ioctl_index,
	input  byte_addr_t ioctl_addr,
	input  half_t      ioctl_dout,
	input  logic       ioctl_wr,
	output logic       ioctl_wait,
	// boot-ROM write port
	output rom_addr_t  pifrom_wraddress,
	output word_t      pifrom_wrdata,
	output logic       pifrom_wren,
	// RAM write channel
	output byte_addr_t ram_wraddr,
	output word_t      ram_wrdata,
	output logic       ram_wr,
	input  logic       ram_ready,
	// main-console ROM status
	output logic       romcopy_start,
	output byte_addr_t romcopy_size,
	output logic       cart_loaded
);

	beat_if u_beat_if ();
	word_if u_word_if ();

	beat_capture u_beat_capture (
		.clk_1x         (clk_1x),
		.arst_n         (arst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wr       (ioctl_wr),
		.beat           (u_beat_if),
		.romcopy_start  (romcopy_start),
		.romcopy_size   (romcopy_size),
		.cart_loaded    (cart_loaded)
	);

	word_assembler u_word_assembler (
		.clk_1x (clk_1x),
		.arst_n (arst_n),
		.beat   (u_beat_if),
		.word   (u_word_if)
	);

	write_router u_write_router (
		.clk_1x           (clk_1x),
		.arst_n           (arst_n),
		.word             (u_word_if),
		.pifrom_wraddress (pifrom_wraddress),
		.pifrom_wrdata    (pifrom_wrdata),
		.pifrom_wren      (pifrom_wren),
		.ram_wraddr       (ram_wraddr),
		.ram_wrdata       (ram_wrdata),
		.ram_wr           (ram_wr),
		.ram_ready        (ram_ready),
		.ioctl_download   (ioctl_download),
		.ioctl_index      (ioctl_index),
		.ioctl_wait       (ioctl_wait)
	);

endmodule

// ==== src/loader_if.sv ====
// stage-to-stage links of the loader pipeline
// beat_if carries single host halves, word_if carries assembled words
// src modport drives, dst modport receives

`timescale 1ns/1ps

// one registered host half
interface beat_if import loader_pkg::*; ();
	// one-cycle strobe per half
	logic       wr;
	dl_kind_t   kind;
	byte_addr_t addr;
	half_t      data;
	// boot-ROM bank from index
	logic       bank;

	modport src (
		output wr, kind, addr, data, bank
	);

	modport dst (
		input wr, kind, addr, data, bank
	);
endinterface

// one complete 32-bit word
interface word_if import loader_pkg::*; ();
	// one-cycle pulse per word
	logic       valid;
	dl_kind_t   kind;
	// byte address of the low half
	byte_addr_t addr;
	logic       bank;
	word_t      data;

	modport src (
		output valid, kind, addr, bank, data
	);

	modport dst (
		input valid, kind, addr, bank, data
	);
endinterface

// ==== src/loader_pkg.sv ====
// shared widths, types and codes for the cartridge and boot-ROM loader
// imported by every loader module, interface and the testbench
// index codes match the host menu entries of the download port

package loader_pkg;

	// ========================================================================
	// bus widths
	// ========================================================================

	// one host transfer is a 16-bit half
	localparam int HALF_W     = 16;
	// two halves make one write word
	localparam int WORD_W     = 32;
	// host byte address, also the RAM write address
	localparam int ADDR_W     = 27;
	// boot-ROM word address incl bank bit
	localparam int ROM_ADDR_W = 10;
	// download index from the host menu
	localparam int INDEX_W    = 8;

	typedef logic [HALF_W-1:0]     half_t;
	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [ADDR_W-1:0]     byte_addr_t;
	typedef logic [ROM_ADDR_W-1:0] rom_addr_t;
	typedef logic [INDEX_W-1:0]    dl_index_t;

	// ========================================================================
	// download classification
	// ========================================================================

	// kind of the running download
	typedef enum logic [1:0] {
		DL_NONE,
		DL_PIF,
		DL_N64,
		DL_GB
	} dl_kind_t;

	// router FSM, waits for the RAM ack after a cartridge word
	typedef enum logic [0:0] {
		ROUTE_IDLE,
		ROUTE_WAIT_RAM
	} route_state_t;

	// only the low index bits select the target
	localparam int IDX_CODE_W = 6;
	// upper index bit picks the boot-ROM bank
	localparam int IDX_BANK_BIT = 6;

	// boot ROM
	localparam logic [IDX_CODE_W-1:0] IDX_PIF = 6'd0;
	// main-console ROM
	localparam logic [IDX_CODE_W-1:0] IDX_N64 = 6'd1;
	// handheld cartridge image
	localparam logic [IDX_CODE_W-1:0] IDX_GB  = 6'd2;

	// handheld image sits at 8 MiB in RAM
	localparam byte_addr_t GB_RAM_BASE = 27'd8388608;

endpackage

// ==== src/word_assembler.sv ====
// second loader stage, pairs two host halves into one 32-bit word
// low half (addr bit 1 clear) is held, high half completes the word
// boot-ROM words get the byte swap of the ROM port, cartridge words go as is

`timescale 1ns/1ps

module word_assembler import loader_pkg::*; (
	input  logic clk_1x,
	input  logic arst_n,
	beat_if.dst  beat,
	word_if.src  word
);

	// ========================================================================
	// low half holding registers
	// ========================================================================

	half_t      lo_data;
	byte_addr_t lo_addr;
	logic       lo_bank;
	logic       lo_beat;
	logic       hi_beat;
	word_t      next_data;

	// addr bit 1 tells the halves apart
	assign lo_beat = beat.wr && !beat.addr[1];
	assign hi_beat = beat.wr && beat.addr[1];

	always_ff @(posedge clk_1x) begin
		if (lo_beat) begin
			lo_data <= beat.data;
			// word address and bank come from the low half
			lo_addr <= beat.addr;
			lo_bank <= beat.bank;
		end
	end

	// ========================================================================
	// word build
	// ========================================================================

	always_comb begin
		if (beat.kind == DL_PIF) begin
			// boot ROM, bytes swapped inside each half
			next_data = {
				lo_data[7:0],
				lo_data[15:8],
				beat.data[7:0],
				beat.data[15:8]
			};
		end else begin
			// cartridge, low half in the low bits
			next_data = {beat.data, lo_data};
		end
	end

	// valid one cycle after the high half
	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			word.valid <= 1'b0;
		end else begin
			word.valid <= hi_beat;
		end
	end

	always_ff @(posedge clk_1x) begin
		if (hi_beat) begin
			word.data <= next_data;
			word.addr <= lo_addr;
			word.bank <= lo_bank;
			// kind of the high half, both halves share one download
			word.kind <= beat.kind;
		end
	end

endmodule

// ==== src/write_router.sv ====
// last loader stage, sends each word to its target
// boot-ROM words go to the ROM write port, cartridge words to the RAM channel
// a cartridge write holds the host off with ioctl_wait until the RAM acks
// only one RAM request is outstanding at any time

`timescale 1ns/1ps

module write_router import loader_pkg::*; (
	input  logic       clk_1x,
	input  logic       arst_n,
	word_if.dst        word,
	output rom_addr_t  pifrom_wraddress,
	output word_t      pifrom_wrdata,
	output logic       pifrom_wren,
	output byte_addr_t ram_wraddr,
	output word_t      ram_wrdata,
	output logic       ram_wr,
	input  logic       ram_ready,
	input  logic       ioctl_download,
	input  dl_index_t  ioctl_index,
	output logic       ioctl_wait
);

	route_state_t state;
	logic         pif_word;
	logic         gb_word;
	logic         gb_dl;

	assign pif_word = word.valid && (word.kind == DL_PIF);
	assign gb_word  = word.valid && (word.kind == DL_GB);

	// raw host level, so the wait drops as soon as the download ends
	assign gb_dl = ioctl_download && (ioctl_index[IDX_CODE_W-1:0] == IDX_GB);

	// ========================================================================
	// write strobes and wait FSM
	// ========================================================================

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			pifrom_wren <= 1'b0;
			ram_wr      <= 1'b0;
			state       <= ROUTE_IDLE;
		end else begin
			pifrom_wren <= pif_word;
			ram_wr      <= gb_word;
			case (state)
				ROUTE_IDLE: begin
					// wait rises with ram_wr
					if (gb_word) begin
						state <= ROUTE_WAIT_RAM;
					end
				end
				ROUTE_WAIT_RAM: begin
					// ack or aborted download releases the host
					if (ram_ready || !gb_dl) begin
						state <= ROUTE_IDLE;
					end
				end
				default: begin
					state <= ROUTE_IDLE;
				end
			endcase
		end
	end

	// wait level straight from the state register
	assign ioctl_wait = (state == ROUTE_WAIT_RAM);

	// ========================================================================
	// address and data, held until the next request
	// ========================================================================

	always_ff @(posedge clk_1x) begin
		if (pif_word) begin
			// bank bit on top of the word address
			pifrom_wraddress <= {word.bank, word.addr[10:2]};
			pifrom_wrdata    <= word.data;
		end
		if (gb_word) begin
			ram_wraddr <= word.addr + GB_RAM_BASE;
			ram_wrdata <= word.data;
		end
	end

	// every incoming word has one of the two targets
	a_word_target: assert property (
		@(posedge clk_1x) disable iff (!arst_n)
			word.valid |-> (word.kind == DL_PIF) || (word.kind == DL_GB)
	) else $error("word arrived without a write target");

	// host must respect ioctl_wait, no second request before the ack
	a_no_overlap: assert property (
		@(posedge clk_1x) disable iff (!arst_n) $rose(ram_wr) |-> $past(state) == ROUTE_IDLE
	) else $error("ram_wr issued while a RAM write was still pending");

endmodule

// ==== test/tb_tasks.svh ====
// host drive tasks, output checks and directed tests of the loader testbench
// included inside tb_cart_loader, works on its signals and expected-write queues

// one error line per mismatch
task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
	assert (got === exp) else begin
		$display("Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
		errors++;
	end
endtask

// compare one write strobe with the oldest expected word
task automatic check_write();
	logic [31:0] e_addr;
	word_t       e_data;
	logic        e_ram;
	assert (exp_addr.size() > 0) else begin
		$display("write strobe at %0t without any word sent", $time);
		errors++;
	end
	if (exp_addr.size() > 0) begin
		e_addr = exp_addr.pop_front();
		e_data = exp_data.pop_front();
		e_ram  = exp_ram.pop_front();
		check_value("ram_wr", 32'(ram_wr), 32'(e_ram));
		check_value("pifrom_wren", 32'(pifrom_wren), 32'(!e_ram));
		check_value("write cycle", 32'(cyc), 32'(exp_edge.pop_front()));
		if (e_ram) begin
			check_value("ram_wraddr", 32'(ram_wraddr), e_addr);
			check_value("ram_wrdata", ram_wrdata, e_data);
		end else begin
			check_value("pifrom_wraddress", 32'(pifrom_wraddress), e_addr);
			check_value("pifrom_wrdata", pifrom_wrdata, e_data);
		end
	end
endtask

// sampled mid-cycle, away from the drive edge
task automatic watch_outputs();
	forever begin
		@(negedge clk_1x);
		if (arst_n) begin
			if (pifrom_wren || ram_wr) begin
				check_write();
			end
			// wait is high from ram_wr until the edge after ram_ready
			if (ram_wr) begin
				exp_wait = 1'b1;
			end
			check_value("ioctl_wait", 32'(ioctl_wait), 32'(exp_wait));
			if (ram_ready) begin
				exp_wait = 1'b0;
			end
			if (romcopy_start) begin
				copy_count++;
				copy_edge = cyc;
				copy_size = romcopy_size;
			end
		end
	end
endtask

// RAM ack model, 1 to 8 cycles after each request
task automatic answer_ram();
	int delay;
	forever begin
		@(negedge clk_1x);
		if (ram_wr) begin
			delay = $urandom_range(8, 1);
			repeat (delay) @(posedge clk_1x);
			#DRIVE_DLY;
			ram_ready = 1'b1;
			@(posedge clk_1x);
			#DRIVE_DLY;
			ram_ready = 1'b0;
		end
	end
endtask

// one host half, strobe held for one cycle
task automatic drive_half(input byte_addr_t addr, input half_t data, output int edge_no);
	@(posedge clk_1x);
	#DRIVE_DLY;
	ioctl_addr = addr;
	ioctl_dout = data;
	ioctl_wr   = 1'b1;
	// DUT samples on the next edge
	edge_no    = cyc + 1;
	@(posedge clk_1x);
	#DRIVE_DLY;
	ioctl_wr = 1'b0;
endtask

// host back-off after a high half, then poll the wait level
task automatic wait_released();
	int n = 0;
	repeat (4) @(posedge clk_1x);
	#DRIVE_DLY;
	while (ioctl_wait && n < WAIT_LIMIT) begin
		@(posedge clk_1x);
		#DRIVE_DLY;
		n++;
	end
	if (ioctl_wait) begin
		$display("ioctl_wait never fell at %0t, host timed out", $time);
		errors++;
	end
endtask

// every queued word must have shown up
task automatic drain_expected();
	int n = 0;
	while (exp_addr.size() > 0 && n < WAIT_LIMIT) begin
		@(posedge clk_1x);
		n++;
	end
	repeat (4) @(posedge clk_1x);
	#DRIVE_DLY;
	assert (exp_addr.size() == 0) else begin
		$display("%0d expected writes never appeared", exp_addr.size());
		errors++;
	end
endtask

// stream random words, queue the writes they must cause, end at the byte count
task automatic run_download(input dl_index_t idx, input int words, input byte_addr_t start,
		output int fall_edge);
	logic       to_ram;
	logic       writes;
	byte_addr_t a;
	word_t      w;
	int         e;
	to_ram = (idx[IDX_CODE_W-1:0] == IDX_GB);
	writes = (idx[IDX_CODE_W-1:0] == IDX_PIF) || to_ram;
	@(posedge clk_1x);
	#DRIVE_DLY;
	ioctl_index    = idx;
	ioctl_download = 1'b1;
	for (int i = 0; i < words; i++) begin
		a = start + byte_addr_t'(i * 4);
		w = $urandom();
		drive_half(a, w[15:0], e);
		drive_half(a | byte_addr_t'(2), w[31:16], e);
		if (writes) begin
			exp_edge.push_back(e + 3);
			exp_ram.push_back(to_ram);
			if (to_ram) begin
				exp_addr.push_back(32'(a) + 32'(GB_RAM_BASE));
				exp_data.push_back(w);
			end else begin
				exp_addr.push_back(32'({idx[IDX_BANK_BIT], a[10:2]}));
				// bytes swapped inside each half
				exp_data.push_back({w[7:0], w[15:8], w[23:16], w[31:24]});
			end
		end
		wait_released();
	end
	@(posedge clk_1x);
	#DRIVE_DLY;
	ioctl_addr     = start + byte_addr_t'(words * 4);
	ioctl_download = 1'b0;
	fall_edge      = cyc;
	drain_expected();
endtask

task automatic report_test(input string name, input int errors_before);
	tests++;
	$display("%s: %0d errors", name, errors - errors_before);
endtask

// ============================================================================
// directed tests
// ============================================================================

task automatic test_reset();
	int e0 = errors;
	check_value("pifrom_wren", 32'(pifrom_wren), 32'd0);
	check_value("ram_wr", 32'(ram_wr), 32'd0);
	check_value("ioctl_wait", 32'(ioctl_wait), 32'd0);
	check_value("romcopy_start", 32'(romcopy_start), 32'd0);
	check_value("cart_loaded", 32'(cart_loaded), 32'd0);
	report_test("reset state", e0);
endtask

task automatic test_boot_rom();
	int e0 = errors;
	int f;
	run_download(8'h00, 16, byte_addr_t'($urandom_range(1023, 0) << 2), f);
	// bank bit set
	run_download(8'h40, 16, byte_addr_t'($urandom_range(1023, 0) << 2), f);
	report_test("boot-ROM load", e0);
endtask

task automatic test_cart();
	int e0 = errors;
	int f;
	run_download(8'h02, 12, byte_addr_t'($urandom_range(65535, 0) << 2), f);
	report_test("cartridge load", e0);
endtask

task automatic test_console();
	int e0 = errors;
	int copies0 = copy_count;
	int f;
	check_value("cart_loaded", 32'(cart_loaded), 32'd0);
	run_download(8'h01, 8, byte_addr_t'(27'h100), f);
	check_value("romcopy_start pulses", 32'(copy_count - copies0), 32'd1);
	// second edge after the fall
	check_value("romcopy_start cycle", 32'(copy_edge), 32'(f + 2));
	check_value("romcopy_size", 32'(copy_size), 32'h120);
	check_value("cart_loaded", 32'(cart_loaded), 32'd1);
	report_test("main-console load end", e0);
endtask

task automatic test_other_index();
	int e0 = errors;
	int copies0 = copy_count;
	int f;
	run_download(8'h03, 8, byte_addr_t'(0), f);
	check_value("romcopy_start pulses", 32'(copy_count - copies0), 32'd0);
	report_test("other index", e0);
endtask

// ==== test/tb_cart_loader.sv ====
// testbench top for the cartridge and boot-ROM loader
// drives the host download port, answers RAM writes and checks every output
// directed tests live in tb_tasks.svh, run.sh builds and runs it

`timescale 1ns/1ps

module tb_cart_loader import loader_pkg::*; ();

	localparam int HALF_PERIOD  = 20;
	localparam int DRIVE_DLY    = 2;
	localparam int RESET_CYCLES = 10;
	localparam int WAIT_LIMIT   = 64;
	localparam logic [31:0] SEED = 32'h4fd65232;

	logic       clk_1x;
	logic       arst_n;
	logic       ioctl_download;
	dl_index_t  ioctl_index;
	byte_addr_t ioctl_addr;
	half_t      ioctl_dout;
	logic       ioctl_wr;
	logic       ioctl_wait;
	rom_addr_t  pifrom_wraddress;
	word_t      pifrom_wrdata;
	logic       pifrom_wren;
	byte_addr_t ram_wraddr;
	word_t      ram_wrdata;
	logic       ram_wr;
	logic       ram_ready;
	logic       romcopy_start;
	byte_addr_t romcopy_size;
	logic       cart_loaded;

	// expected writes, oldest first
	logic [31:0] exp_addr[$];
	word_t       exp_data[$];
	int          exp_edge[$];
	logic        exp_ram[$];

	int         cyc = 0;
	int         errors = 0;
	int         tests = 0;
	int         copy_count = 0;
	int         copy_edge = 0;
	byte_addr_t copy_size;
	logic       exp_wait;

	`include "tb_tasks.svh"

	cart_loader_top u_cart_loader_top (.*);

	initial begin
		clk_1x = 1'b0;
		forever #HALF_PERIOD clk_1x = ~clk_1x;
	end

	// edge counter for the latency checks
	always @(posedge clk_1x) begin
		cyc <= cyc + 1;
	end

	initial begin
		void'($urandom(SEED));
		arst_n         = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_wr       = 1'b0;
		ram_ready      = 1'b0;
		exp_wait       = 1'b0;
		fork
			watch_outputs();
			answer_ram();
		join_none
		repeat (RESET_CYCLES) @(posedge clk_1x);
		#DRIVE_DLY;
		arst_n = 1'b1;
		test_reset();
		test_boot_rom();
		test_cart();
		test_console();
		test_other_index();
		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
